// File: verilog/mipsPkg.sv
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	// where an operand comes from: register file, memory stage or write-back
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSelT;

	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opSw = 6'b101011;
	localparam logic [5:0] opBeq = 6'b000100;

	// funct field, only valid under opSpecial
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnSlt = 6'b101010;

	// operand select used by the branch compare and by both ALU inputs
	function automatic wordT fwdMux(input fwdSelT sel, input wordT regVal, input wordT memVal,
			input wordT wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

endpackage

// File: verilog/regFile.sv
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic rstN_i,
	input mipsPkg::regAddrT raddrA_i,
	input mipsPkg::regAddrT raddrB_i,
	input mipsPkg::regAddrT waddr_i,
	input logic we_i,
	input mipsPkg::wordT wdata_i,
	output mipsPkg::wordT rdataA_o,
	output mipsPkg::wordT rdataB_o
);
	import mipsPkg::*;

	wordT regs [32];

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// r0 reads zero, same-cycle write wins over the stored value
	assign rdataA_o = (raddrA_i == '0) ? '0 :
		(we_i && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
	assign rdataB_o = (raddrB_i == '0) ? '0 :
		(we_i && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

// File: verilog/fetchStage.sv
`timescale 1ns/100ps

module fetchStage #(
	parameter mipsPkg::wordT resetPc = 32'hBFC00000
) (
	input logic clk,
	input logic rstN_i,
	input logic stallF_i,
	input logic stallD_i,
	input logic branchTaken_i,
	input mipsPkg::wordT branchTarget_i,
	output mipsPkg::wordT pc_o,
	output mipsPkg::wordT pcD_o
);
	import mipsPkg::*;

	wordT pc, pcD, nextPc;

	// delay slot is already being fetched, a taken branch just redirects the pc
	assign nextPc = branchTaken_i ? branchTarget_i : pc + 32'd4;

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			pc <= resetPc;
		end else if (!stallF_i) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD_i) begin
			pcD <= pc;
		end
	end

	// while decode is held, re-read its word so the sram output keeps showing it
	assign pc_o = stallD_i ? pcD : pc;
	assign pcD_o = pcD;

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
	input logic clk,
	input logic rstN_i,
	input mipsPkg::wordT instr_i,
	input mipsPkg::wordT pcD_i,
	input logic wbWe_i,
	input mipsPkg::regAddrT wbAddr_i,
	input mipsPkg::wordT wbData_i,
	input mipsPkg::wordT memFwd_i,
	input mipsPkg::fwdSelT fwdSelA_i,
	input mipsPkg::fwdSelT fwdSelB_i,
	input logic flushE_i,
	input logic stallD_i,
	output logic branchTaken_o,
	output mipsPkg::wordT branchTarget_o,
	output mipsPkg::regAddrT rsD_o,
	output mipsPkg::regAddrT rtD_o,
	output logic isBranchD_o,
	output mipsPkg::regAddrT rsE_o,
	output mipsPkg::regAddrT rtE_o,
	output mipsPkg::regAddrT destE_o,
	output mipsPkg::aluOpT aluOpE_o,
	output logic useImmE_o,
	output logic regWriteE_o,
	output logic memReadE_o,
	output logic memWriteE_o,
	output mipsPkg::wordT aEq_o,
	output mipsPkg::wordT bE_o,
	output mipsPkg::wordT immE_o,
	output mipsPkg::wordT pcE_o
);
	import mipsPkg::*;

	logic instrValid;	// low for the first cycle after reset, sram not read yet
	logic [5:0] opcode, funct;
	regAddrT rs, rt, rd, dest;
	wordT imm, rdataA, rdataB, opA, opB;
	aluOpT aluOp;
	logic useImm, regWrite, memRead, memWrite, isBranch, useRt;

	assign opcode = instr_i[31:26];
	assign rs = instr_i[25:21];
	assign rt = instr_i[20:16];
	assign rd = instr_i[15:11];
	assign funct = instr_i[5:0];
	assign imm = {{16{instr_i[15]}}, instr_i[15:0]};

	regFile rf (
		.clk(clk),
		.rstN_i(rstN_i),
		.raddrA_i(rs),
		.raddrB_i(rt),
		.waddr_i(wbAddr_i),
		.we_i(wbWe_i),
		.wdata_i(wbData_i),
		.rdataA_o(rdataA),
		.rdataB_o(rdataB)
	);

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			instrValid <= 1'b0;
		end else begin
			instrValid <= 1'b1;
		end
	end

	always_comb begin
		aluOp = aluAdd;
		useImm = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		isBranch = 1'b0;
		useRt = 1'b0;
		dest = rd;
		if (instrValid) begin
			case (opcode)
				opSpecial: begin
					regWrite = 1'b1;
					useRt = 1'b1;
					case (funct)
						fnAddu: aluOp = aluAdd;
						fnSubu: aluOp = aluSub;
						fnAnd: aluOp = aluAnd;
						fnOr: aluOp = aluOr;
						fnSlt: aluOp = aluSlt;
						default: begin
							regWrite = 1'b0;
							useRt = 1'b0;
						end
					endcase
				end
				opAddiu: begin
					useImm = 1'b1;
					regWrite = 1'b1;
					dest = rt;
				end
				opLw: begin
					useImm = 1'b1;
					regWrite = 1'b1;
					memRead = 1'b1;
					dest = rt;
				end
				opSw: begin
					useImm = 1'b1;
					memWrite = 1'b1;
					useRt = 1'b1;
				end
				opBeq: begin
					isBranch = 1'b1;
					useRt = 1'b1;
				end
				default: ;	// anything else retires as a no-op
			endcase
		end
	end

	// unused source fields read as r0 so they never trigger a hazard
	assign rsD_o = (regWrite || memWrite || isBranch) ? rs : '0;
	assign rtD_o = useRt ? rt : '0;
	assign isBranchD_o = isBranch;

	assign opA = fwdMux(fwdSelA_i, rdataA, memFwd_i, wbData_i);
	assign opB = fwdMux(fwdSelB_i, rdataB, memFwd_i, wbData_i);
	assign branchTaken_o = isBranch && (opA == opB) && !stallD_i;	// stalled operands are stale
	assign branchTarget_o = pcD_i + 32'd4 + {imm[29:0], 2'b00};

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			regWriteE_o <= 1'b0;
			memReadE_o <= 1'b0;
			memWriteE_o <= 1'b0;
		end else if (flushE_i) begin
			regWriteE_o <= 1'b0;
			memReadE_o <= 1'b0;
			memWriteE_o <= 1'b0;
		end else begin
			regWriteE_o <= regWrite && (dest != '0);
			memReadE_o <= memRead;
			memWriteE_o <= memWrite;
		end
	end

	always_ff @(posedge clk) begin
		rsE_o <= rsD_o;
		rtE_o <= rtD_o;
		destE_o <= dest;
		aluOpE_o <= aluOp;
		useImmE_o <= useImm;
		aEq_o <= rdataA;
		bE_o <= rdataB;
		immE_o <= imm;
		pcE_o <= pcD_i;
	end

	// the instruction held in decode must not also show up in execute
	assert property (@(posedge clk) disable iff (!rstN_i)
		stallD_i |=> !(regWriteE_o || memReadE_o || memWriteE_o));

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/100ps

module executeStage (
	input logic clk,
	input logic rstN_i,
	input mipsPkg::regAddrT destE_i,
	input mipsPkg::aluOpT aluOpE_i,
	input logic useImmE_i,
	input logic regWriteE_i,
	input logic memReadE_i,
	input logic memWriteE_i,
	input mipsPkg::wordT aE_i,
	input mipsPkg::wordT bE_i,
	input mipsPkg::wordT immE_i,
	input mipsPkg::wordT pcE_i,
	input mipsPkg::fwdSelT fwdSelA_i,
	input mipsPkg::fwdSelT fwdSelB_i,
	input mipsPkg::wordT memFwd_i,
	input mipsPkg::wordT wbFwd_i,
	output mipsPkg::wordT aluResM_o,
	output mipsPkg::wordT storeDataM_o,
	output mipsPkg::regAddrT destM_o,
	output logic regWriteM_o,
	output logic memReadM_o,
	output logic memWriteM_o,
	output mipsPkg::wordT pcM_o
);
	import mipsPkg::*;

	wordT srcA, srcB, opB, aluRes;

	assign srcA = fwdMux(fwdSelA_i, aE_i, memFwd_i, wbFwd_i);
	assign srcB = fwdMux(fwdSelB_i, bE_i, memFwd_i, wbFwd_i);
	assign opB = useImmE_i ? immE_i : srcB;	// srcB stays the store data for sw

	always_comb begin
		case (aluOpE_i)
			aluSub: aluRes = srcA - opB;
			aluAnd: aluRes = srcA & opB;
			aluOr: aluRes = srcA | opB;
			aluSlt: aluRes = {{(dataWidth-1){1'b0}}, $signed(srcA) < $signed(opB)};
			default: aluRes = srcA + opB;	// addu, addiu and address calc, no overflow trap
		endcase
	end

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			regWriteM_o <= 1'b0;
			memReadM_o <= 1'b0;
			memWriteM_o <= 1'b0;
		end else begin
			regWriteM_o <= regWriteE_i;
			memReadM_o <= memReadE_i;
			memWriteM_o <= memWriteE_i;
		end
	end

	always_ff @(posedge clk) begin
		aluResM_o <= aluRes;
		storeDataM_o <= srcB;
		destM_o <= destE_i;
		pcM_o <= pcE_i;
	end

endmodule

// File: verilog/memoryStage.sv
`timescale 1ns/100ps

module memoryStage (
	input logic clk,
	input logic rstN_i,
	input mipsPkg::wordT aluResM_i,
	input mipsPkg::wordT storeDataM_i,
	input mipsPkg::regAddrT destM_i,
	input logic regWriteM_i,
	input logic memReadM_i,
	input logic memWriteM_i,
	input mipsPkg::wordT pcM_i,
	input mipsPkg::wordT dataSramRdata_i,
	output logic dataSramEn_o,
	output logic [3:0] dataSramWen_o,
	output mipsPkg::wordT dataSramAddr_o,
	output mipsPkg::wordT dataSramWdata_o,
	output logic wbWe_o,
	output mipsPkg::regAddrT wbAddr_o,
	output mipsPkg::wordT wbData_o,
	output mipsPkg::wordT memFwd_o,
	output mipsPkg::wordT debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output mipsPkg::regAddrT debugWbRfWnum_o,
	output mipsPkg::wordT debugWbRfWdata_o
);
	import mipsPkg::*;

	logic loadW;
	wordT resW, pcW;

	assign dataSramEn_o = memReadM_i || memWriteM_i;
	assign dataSramWen_o = {4{memWriteM_i}};	// word stores only
	assign dataSramAddr_o = aluResM_i;
	assign dataSramWdata_o = storeDataM_i;
	assign memFwd_o = aluResM_i;

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			wbWe_o <= 1'b0;
			loadW <= 1'b0;
		end else begin
			wbWe_o <= regWriteM_i;
			loadW <= memReadM_i;
		end
	end

	always_ff @(posedge clk) begin
		wbAddr_o <= destM_i;
		resW <= aluResM_i;
		pcW <= pcM_i;
	end

	// load data arrives from the sram one cycle after the address, in write-back
	assign wbData_o = loadW ? dataSramRdata_i : resW;

	assign debugWbPc_o = pcW;
	assign debugWbRfWen_o = {4{wbWe_o}};
	assign debugWbRfWnum_o = wbAddr_o;
	assign debugWbRfWdata_o = wbData_o;

	// write strobes only ever come from a store, never alongside a load
	assert property (@(posedge clk) disable iff (!rstN_i)
		(dataSramWen_o != 4'b0000) |-> !memReadM_i);

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
	input mipsPkg::regAddrT rsD_i,
	input mipsPkg::regAddrT rtD_i,
	input mipsPkg::regAddrT rsE_i,
	input mipsPkg::regAddrT rtE_i,
	input mipsPkg::regAddrT destE_i,
	input mipsPkg::regAddrT destM_i,
	input mipsPkg::regAddrT destW_i,
	input logic regWriteE_i,
	input logic regWriteM_i,
	input logic regWriteW_i,
	input logic memReadE_i,
	input logic memReadM_i,
	input logic isBranchD_i,
	output logic stallF_o,
	output logic stallD_o,
	output logic flushE_o,
	output mipsPkg::fwdSelT fwdSelAD_o,
	output mipsPkg::fwdSelT fwdSelBD_o,
	output mipsPkg::fwdSelT fwdSelAE_o,
	output mipsPkg::fwdSelT fwdSelBE_o
);
	import mipsPkg::*;

	logic loadUse, branchWait, stall;

	// memory stage holds the younger result, so it is checked first
	function automatic fwdSelT pickSrc(input regAddrT src, input logic weM, input regAddrT dM,
			input logic weW, input regAddrT dW);
		if (src != '0 && weM && dM == src) return fwdMem;
		if (src != '0 && weW && dW == src) return fwdWb;
		return fwdReg;
	endfunction

	function automatic logic hits(input regAddrT dest, input regAddrT a, input regAddrT b);
		return dest != '0 && (dest == a || dest == b);
	endfunction

	assign fwdSelAD_o = pickSrc(rsD_i, regWriteM_i, destM_i, regWriteW_i, destW_i);
	assign fwdSelBD_o = pickSrc(rtD_i, regWriteM_i, destM_i, regWriteW_i, destW_i);
	assign fwdSelAE_o = pickSrc(rsE_i, regWriteM_i, destM_i, regWriteW_i, destW_i);
	assign fwdSelBE_o = pickSrc(rtE_i, regWriteM_i, destM_i, regWriteW_i, destW_i);

	assign loadUse = memReadE_i && hits(destE_i, rsD_i, rtD_i);
	// branch compares in decode, so a result still in execute or a load in memory is too late
	assign branchWait = isBranchD_i && ((regWriteE_i && hits(destE_i, rsD_i, rtD_i)) ||
		(memReadM_i && hits(destM_i, rsD_i, rtD_i)));

	assign stall = loadUse || branchWait;
	assign stallF_o = stall;
	assign stallD_o = stall;
	assign flushE_o = stall;	// bubble into execute while decode waits

endmodule

// File: verilog/mipsTop.sv
`timescale 1ns/100ps

module mipsTop #(
	parameter mipsPkg::wordT resetPc = 32'hBFC00000
) (
	input logic clk,
	input logic rstN_i,
	input mipsPkg::wordT instSramRdata_i,
	input mipsPkg::wordT dataSramRdata_i,
	output logic instSramEn_o,
	output mipsPkg::wordT instSramAddr_o,
	output logic dataSramEn_o,
	output logic [3:0] dataSramWen_o,
	output mipsPkg::wordT dataSramAddr_o,
	output mipsPkg::wordT dataSramWdata_o,
	output mipsPkg::wordT debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output mipsPkg::regAddrT debugWbRfWnum_o,
	output mipsPkg::wordT debugWbRfWdata_o
);
	import mipsPkg::*;

	logic stallF, stallD, flushE;
	fwdSelT fwdSelAD, fwdSelBD, fwdSelAE, fwdSelBE;
	logic branchTaken, isBranchD;
	wordT branchTarget, pcD;
	regAddrT rsD, rtD, rsE, rtE, destE, destM, wbAddr;
	aluOpT aluOpE;
	logic useImmE, regWriteE, memReadE, memWriteE;
	wordT aE, bE, immE, pcE;
	wordT aluResM, storeDataM, pcM;
	logic regWriteM, memReadM, memWriteM, wbWe;
	wordT wbData, memFwd;

	assign instSramEn_o = 1'b1;	// fetch every cycle, a stall just re-reads

	fetchStage #(
		.resetPc(resetPc)
	) fetch (
		.clk(clk),
		.rstN_i(rstN_i),
		.stallF_i(stallF),
		.stallD_i(stallD),
		.branchTaken_i(branchTaken),
		.branchTarget_i(branchTarget),
		.pc_o(instSramAddr_o),
		.pcD_o(pcD)
	);

	decodeStage decode (
		.clk(clk),
		.rstN_i(rstN_i),
		.instr_i(instSramRdata_i),
		.pcD_i(pcD),
		.wbWe_i(wbWe),
		.wbAddr_i(wbAddr),
		.wbData_i(wbData),
		.memFwd_i(memFwd),
		.fwdSelA_i(fwdSelAD),
		.fwdSelB_i(fwdSelBD),
		.flushE_i(flushE),
		.stallD_i(stallD),
		.branchTaken_o(branchTaken),
		.branchTarget_o(branchTarget),
		.rsD_o(rsD),
		.rtD_o(rtD),
		.isBranchD_o(isBranchD),
		.rsE_o(rsE),
		.rtE_o(rtE),
		.destE_o(destE),
		.aluOpE_o(aluOpE),
		.useImmE_o(useImmE),
		.regWriteE_o(regWriteE),
		.memReadE_o(memReadE),
		.memWriteE_o(memWriteE),
		.aEq_o(aE),
		.bE_o(bE),
		.immE_o(immE),
		.pcE_o(pcE)
	);

	executeStage execute (
		.clk(clk),
		.rstN_i(rstN_i),
		.destE_i(destE),
		.aluOpE_i(aluOpE),
		.useImmE_i(useImmE),
		.regWriteE_i(regWriteE),
		.memReadE_i(memReadE),
		.memWriteE_i(memWriteE),
		.aE_i(aE),
		.bE_i(bE),
		.immE_i(immE),
		.pcE_i(pcE),
		.fwdSelA_i(fwdSelAE),
		.fwdSelB_i(fwdSelBE),
		.memFwd_i(memFwd),
		.wbFwd_i(wbData),
		.aluResM_o(aluResM),
		.storeDataM_o(storeDataM),
		.destM_o(destM),
		.regWriteM_o(regWriteM),
		.memReadM_o(memReadM),
		.memWriteM_o(memWriteM),
		.pcM_o(pcM)
	);

	memoryStage memory (
		.clk(clk),
		.rstN_i(rstN_i),
		.aluResM_i(aluResM),
		.storeDataM_i(storeDataM),
		.destM_i(destM),
		.regWriteM_i(regWriteM),
		.memReadM_i(memReadM),
		.memWriteM_i(memWriteM),
		.pcM_i(pcM),
		.dataSramRdata_i(dataSramRdata_i),
		.dataSramEn_o(dataSramEn_o),
		.dataSramWen_o(dataSramWen_o),
		.dataSramAddr_o(dataSramAddr_o),
		.dataSramWdata_o(dataSramWdata_o),
		.wbWe_o(wbWe),
		.wbAddr_o(wbAddr),
		.wbData_o(wbData),
		.memFwd_o(memFwd),
		.debugWbPc_o(debugWbPc_o),
		.debugWbRfWen_o(debugWbRfWen_o),
		.debugWbRfWnum_o(debugWbRfWnum_o),
		.debugWbRfWdata_o(debugWbRfWdata_o)
	);

	hazardUnit hazard (
		.rsD_i(rsD),
		.rtD_i(rtD),
		.rsE_i(rsE),
		.rtE_i(rtE),
		.destE_i(destE),
		.destM_i(destM),
		.destW_i(wbAddr),
		.regWriteE_i(regWriteE),
		.regWriteM_i(regWriteM),
		.regWriteW_i(wbWe),
		.memReadE_i(memReadE),
		.memReadM_i(memReadM),
		.isBranchD_i(isBranchD),
		.stallF_o(stallF),
		.stallD_o(stallD),
		.flushE_o(flushE),
		.fwdSelAD_o(fwdSelAD),
		.fwdSelBD_o(fwdSelBD),
		.fwdSelAE_o(fwdSelAE),
		.fwdSelBE_o(fwdSelBE)
	);

endmodule

// File: dv/mipsTopTb.sv
`timescale 1ns/100ps

module mipsTopTb;
	import mipsPkg::*;

	logic clk, rstN_i;
	wordT instSramRdata_i, dataSramRdata_i;
	logic instSramEn_o, dataSramEn_o;
	logic [3:0] dataSramWen_o, debugWbRfWen_o;
	wordT instSramAddr_o, dataSramAddr_o, dataSramWdata_o, debugWbPc_o, debugWbRfWdata_o;
	regAddrT debugWbRfWnum_o;

	wordT imem [256];
	wordT dmem [256];
	wordT expPc [$], expData [$], expMemAddr [$], expMemData [$];
	regAddrT expReg [$];
	wordT instAddrQ, dataAddrQ;
	int errors = 0;

	mipsTop #(.resetPc(32'h0)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// sram models, one cycle read latency, driven 1 ns after the edge
	always @(posedge clk) begin
		if (instSramEn_o) begin
			instAddrQ = instSramAddr_o;
			#1 instSramRdata_i = imem[instAddrQ[9:2]];
		end
	end

	always @(posedge clk) begin
		if (dataSramEn_o) begin
			dataAddrQ = dataSramAddr_o;
			if (dataSramWen_o == 4'b1111)
				dmem[dataAddrQ[9:2]] = dataSramWdata_o;
			#1 dataSramRdata_i = dmem[dataAddrQ[9:2]];
		end
	end

	task automatic checkVal(input string name, input wordT exp, input wordT got);
		if (exp !== got) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic checkQuiet();
		checkVal("debugWbRfWen_o", 32'h0, {28'h0, debugWbRfWen_o});
		checkVal("dataSramWen_o", 32'h0, {28'h0, dataSramWen_o});
		checkVal("dataSramEn_o", 32'h0, {31'h0, dataSramEn_o});
	endtask

	task automatic loadCases();
		int fd, r;
		logic [8*8-1:0] tag;
		logic [8*128-1:0] rest;
		wordT a, b, c;
		fd = $fopen("dv/cpuCases.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/cpuCases.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			r = $fscanf(fd, "%s", tag);
			if (r != 1) break;
			if (tag[7:0] == "#") r = $fgets(rest, fd);
			else if (tag[7:0] == "I") begin
				r = $fscanf(fd, "%h %h", a, b);
				imem[a[9:2]] = b;
			end else if (tag[7:0] == "T") begin
				r = $fscanf(fd, "%h %h %h", a, b, c);
				expPc.push_back(a);
				expReg.push_back(b[4:0]);
				expData.push_back(c);
			end else if (tag[7:0] == "M") begin
				r = $fscanf(fd, "%h %h", a, b);
				expMemAddr.push_back(a);
				expMemData.push_back(b);
			end
		end
		$fclose(fd);
	endtask

	task automatic endRun();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		int waited;
		rstN_i = 1'b0;
		instSramRdata_i = '0;
		dataSramRdata_i = '0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'hFC000000 | i;	// unknown opcode, retires as no-op
			dmem[i] = 32'hD0000000 | (i << 2);
		end
		loadCases();

		repeat (5) begin
			@(posedge clk);
			#1 checkQuiet();
		end
		rstN_i = 1'b1;
		#1 checkVal("instSramAddr_o", 32'h0, instSramAddr_o);
		repeat (4) begin
			@(negedge clk);
			checkQuiet();
		end

		for (int n = 0; n < expPc.size(); n++) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (debugWbRfWen_o != 4'b1111 && waited < 50);
			if (debugWbRfWen_o != 4'b1111) begin
				$display("timeout: trace entry %0d never retired", n);
				errors++;
				break;
			end
			checkVal("debugWbPc_o", expPc[n], debugWbPc_o);
			checkVal("debugWbRfWnum_o", {27'h0, expReg[n]}, {27'h0, debugWbRfWnum_o});
			checkVal("debugWbRfWdata_o", expData[n], debugWbRfWdata_o);
		end

		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			if (debugWbRfWen_o != 4'b0000) begin
				$display("unexpected trace entry at pc %h after the last expected one",
					debugWbPc_o);
				errors++;
			end
		end

		foreach (expMemAddr[i]) begin
			checkVal($sformatf("dmem[%h]", expMemAddr[i]), expMemData[i],
				dmem[expMemAddr[i][9:2]]);
		end
		endRun();
	end

endmodule

// File: dv/cpuCases.txt
# I addr word | T pc reg data (write-back order) | M addr word (final data memory)
I 00 24010005
I 04 24020003
I 08 00221821
I 0c 00612023
I 10 00642824
I 14 00643025
I 18 0083382a
I 1c 2408ffff
I 20 0101482a
I 24 ac060010
I 28 8c0a0010
I 2c 01415821
I 30 24000007
I 34 fc000000
I 38 00016021
I 3c 10220004
I 40 240d0001
I 44 240e0002
I 48 8c0f0010
I 4c 11e60002
I 50 24100003
I 54 24110004
I 58 ac0b0014
I 5c 24120006
I 60 1000ffff
I 64 00000000
T 00 01 00000005
T 04 02 00000003
T 08 03 00000008
T 0c 04 00000003
T 10 05 00000000
T 14 06 0000000b
T 18 07 00000001
T 1c 08 ffffffff
T 20 09 00000001
T 28 0a 0000000b
T 2c 0b 00000010
T 38 0c 00000005
T 40 0d 00000001
T 44 0e 00000002
T 48 0f 0000000b
T 50 10 00000003
T 5c 12 00000006
M 10 0000000b
M 14 00000010

// File: mipsLite.f
verilog/mipsPkg.sv
verilog/regFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/hazardUnit.sv
verilog/mipsTop.sv
dv/mipsTopTb.sv

// File: runSim.sh
#!/bin/sh
# build with Verilator and run from the project root
rm -f sim.log
(verilator --binary --timing --assert -Wno-fatal -f mipsLite.f \
	--top-module mipsTopTb -o simv && ./obj_dir/simv) > sim.log 2>&1 \
	|| echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
